// ==== vlog.f ====
+incdir+common
common/lsu_replay_pkg.sv
common/lsu_replay_if.sv
replay_queue/free_list.sv
replay_queue/payload_ram.sv
replay_queue/replay_select.sv
replay_queue/replay_queue.sv
source/lsu_replay_top.sv
bench/tb_lsu_replay.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the replay queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_lsu_replay -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// ==== bench/tb_lsu_replay.sv ====
`include "lsu_replay_config.svh"

module tb_lsu_replay
  import lsu_replay_pkg::*;
();

  localparam int N_TAGS     = 1 << `ROB_TAG_W;
  localparam int MAX_CYCLES = 4000;   // several times the length of all six tests

  logic                    i_clk = 1'b0;
  logic                    i_reset_n;
  logic                    i_push_valid;
  rob_tag_t                i_push_tag;
  haz_type_t               i_push_haz_type;
  haz_mask_t               i_push_haz_mask;
  paddr_t                  i_push_paddr;
  access_size_t            i_push_size;
  logic                    i_stq_resolve_valid;
  logic [`STQ_DEPTH-1:0]   i_stq_resolve_oh;
  logic                    i_missu_full;
  logic                    i_missu_resolve_valid;
  logic [`MISSU_DEPTH-1:0] i_missu_resolve_oh;
  logic                    i_flush;
  logic                    i_replay_ready;
  logic                    o_replay_valid;
  rob_tag_t                o_replay_tag;
  haz_type_t               o_replay_haz_type;
  paddr_t                  o_replay_paddr;
  access_size_t            o_replay_size;
  logic                    o_full;
  logic                    o_almost_full;

  // scoreboard with one row per tag
  paddr_t       sb_paddr [N_TAGS];
  access_size_t sb_size  [N_TAGS];
  haz_type_t    sb_type  [N_TAGS];
  haz_mask_t    sb_mask  [N_TAGS];   // model of the hazard mask
  logic         sb_pend  [N_TAGS];

  int           n_pend    = 0;
  int           err_val   = 0;
  int           err_other = 0;
  int           cycle_cnt = 0;
  logic [31:0]  rng_state = 32'd61;
  rob_tag_t     next_tag  = '0;
  rob_tag_t     last_tag;
  logic         chk_occ   = 1'b1;     // model count matches the queue
  logic         prev_stall = 1'b0;
  rob_tag_t     prev_tag;
  paddr_t       prev_paddr;
  access_size_t prev_size;

  lsu_replay_top i_dut (.*);

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    err_val++;
    $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
  endtask

  task automatic report_error(input string msg);
    err_other++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic idle_inputs();
    i_push_valid          = 1'b0;
    i_stq_resolve_valid   = 1'b0;
    i_stq_resolve_oh      = '0;
    i_missu_full          = 1'b0;
    i_missu_resolve_valid = 1'b0;
    i_missu_resolve_oh    = '0;
    i_flush               = 1'b0;
  endtask

  // called at a falling edge once the inputs of this cycle are driven
  task automatic step_cycle();
    rob_tag_t t;
    t = o_replay_tag;
    if (o_replay_valid) begin
      if (!sb_pend[t]) begin
        report_error($sformatf("tag %0d issued but not pending", t));
      end else begin
        if (sb_mask[t] != '0) begin
          report_error($sformatf("tag %0d issued before its hazard cleared", t));
        end
        if (o_replay_paddr !== sb_paddr[t]) report_mismatch("o_replay_paddr", sb_paddr[t],
                                                            o_replay_paddr);
        if (o_replay_size !== sb_size[t]) report_mismatch("o_replay_size", sb_size[t],
                                                          o_replay_size);
        if (o_replay_haz_type !== sb_type[t]) report_mismatch("o_replay_haz_type", sb_type[t],
                                                              o_replay_haz_type);
      end
    end
    if (prev_stall) begin   // stalled issue must hold
      if (o_replay_valid !== 1'b1) report_mismatch("o_replay_valid", 1, o_replay_valid);
      if (o_replay_tag !== prev_tag) report_mismatch("o_replay_tag", prev_tag, o_replay_tag);
      if (o_replay_paddr !== prev_paddr) report_mismatch("o_replay_paddr", prev_paddr,
                                                         o_replay_paddr);
      if (o_replay_size !== prev_size) report_mismatch("o_replay_size", prev_size,
                                                       o_replay_size);
    end
    if (chk_occ) begin
      if (o_full !== (n_pend == `RQ_DEPTH)) report_mismatch("o_full", n_pend == `RQ_DEPTH,
                                                            o_full);
      if (o_almost_full !== (n_pend >= `RQ_DEPTH - `RQ_ALMOST_MARGIN)) begin
        report_mismatch("o_almost_full", n_pend >= `RQ_DEPTH - `RQ_ALMOST_MARGIN,
                        o_almost_full);
      end
    end
    prev_stall = o_replay_valid && !i_replay_ready && !i_flush;
    prev_tag   = o_replay_tag;
    prev_paddr = o_replay_paddr;
    prev_size  = o_replay_size;

    // transfer at the coming edge
    if (o_replay_valid && i_replay_ready && sb_pend[t]) begin
      sb_pend[t] = 1'b0;
      n_pend--;
    end
    // mask update at the coming edge for entries pushed earlier
    for (int k = 0; k < N_TAGS; k++) begin
      if (sb_pend[k] && i_flush) begin
        sb_pend[k] = 1'b0;   // killed entries must never show up
        n_pend--;
      end else if (sb_pend[k]) begin
        case (sb_type[k])
          HAZ_L1D_CONFLICT : sb_mask[k] = '0;
          HAZ_STQ_WAIT     : begin
            if (i_stq_resolve_valid) sb_mask[k] &= ~haz_mask_t'(i_stq_resolve_oh);
          end
          HAZ_MISSU_FULL   : if (!i_missu_full) sb_mask[k] = '0;
          HAZ_MISSU_WAIT   : begin
            if (i_missu_resolve_valid) sb_mask[k] &= ~haz_mask_t'(i_missu_resolve_oh);
          end
        endcase
      end
    end
    if (i_push_valid) begin
      sb_pend[i_push_tag]  = 1'b1;
      sb_paddr[i_push_tag] = i_push_paddr;
      sb_size[i_push_tag]  = i_push_size;
      sb_type[i_push_tag]  = i_push_haz_type;
      // l1d conflict waits one edge before it is ready
      sb_mask[i_push_tag]  = (i_push_haz_type == HAZ_L1D_CONFLICT) ? haz_mask_t'(1)
                                                                   : i_push_haz_mask;
      n_pend++;
    end
    @(negedge i_clk);
  endtask

  task automatic start_push(input haz_type_t ty, input haz_mask_t mask);
    logic [31:0] r;
    r = next_rand();
    while (sb_pend[next_tag]) begin
      next_tag++;   // skip tags still in flight
    end
    i_push_valid    = 1'b1;
    i_push_tag      = next_tag;
    i_push_haz_type = ty;
    i_push_haz_mask = mask;
    i_push_paddr    = next_rand();
    i_push_size     = r[1:0];
    last_tag        = next_tag;
    next_tag++;
  endtask

  task automatic push_one(input haz_type_t ty, input haz_mask_t mask);
    start_push(ty, mask);
    step_cycle();
    i_push_valid = 1'b0;
  endtask

  // resolve everything and take every issue
  task automatic drain_queue(input int limit);
    int n;
    n = 0;
    i_replay_ready        = 1'b1;
    i_stq_resolve_valid   = 1'b1;
    i_stq_resolve_oh      = '1;
    i_missu_resolve_valid = 1'b1;
    i_missu_resolve_oh    = '1;
    i_missu_full          = 1'b0;
    while (n_pend != 0 && n < limit) begin
      step_cycle();
      n++;
    end
    if (n_pend != 0) report_error($sformatf("%0d tags never issued", n_pend));
    idle_inputs();
    step_cycle();   // queue must be quiet now
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic l1d_conflict_test();
    i_replay_ready = 1'b1;
    push_one(HAZ_L1D_CONFLICT, 8'h00);
    if (o_replay_valid !== 1'b0) report_mismatch("o_replay_valid", 0, o_replay_valid);
    step_cycle();
    if (o_replay_valid !== 1'b1) report_mismatch("o_replay_valid", 1, o_replay_valid);
    if (o_replay_tag !== last_tag) report_mismatch("o_replay_tag", last_tag, o_replay_tag);
    drain_queue(4);
  endtask

  task automatic stq_wait_test();
    logic [39:0] oh_seq = 40'h10_80_01_04_90;   // first step has valid low
    i_replay_ready = 1'b1;
    push_one(HAZ_STQ_WAIT, 8'h94);
    for (int k = 0; k < 5; k++) begin
      i_stq_resolve_valid = (k != 0);
      i_stq_resolve_oh    = oh_seq[8*k +: 8];
      step_cycle();
      if (o_replay_valid !== (k == 4)) report_mismatch("o_replay_valid", k == 4,
                                                       o_replay_valid);
    end
    idle_inputs();
    drain_queue(4);
  endtask

  task automatic missu_test();
    i_replay_ready = 1'b1;
    i_missu_full   = 1'b1;
    push_one(HAZ_MISSU_FULL, 8'h01);
    repeat (5) begin
      step_cycle();
      if (o_replay_valid !== 1'b0) report_mismatch("o_replay_valid", 0, o_replay_valid);
    end
    i_missu_full = 1'b0;
    step_cycle();
    if (o_replay_valid !== 1'b1) report_mismatch("o_replay_valid", 1, o_replay_valid);
    drain_queue(4);

    push_one(HAZ_MISSU_WAIT, 8'h0a);
    i_missu_resolve_valid = 1'b1;
    for (int k = 0; k < 3; k++) begin
      i_missu_resolve_oh = (k == 0) ? 4'b0010 : (k == 1) ? 4'b0001 : 4'b1000;
      step_cycle();
      if (o_replay_valid !== (k == 2)) report_mismatch("o_replay_valid", k == 2,
                                                       o_replay_valid);
    end
    idle_inputs();
    drain_queue(4);
  endtask

  task automatic backpressure_test();
    i_replay_ready = 1'b0;
    for (int k = 0; k < `RQ_DEPTH; k++) begin
      push_one(HAZ_L1D_CONFLICT, 8'h00);
      if (o_almost_full !== (k >= 3)) report_mismatch("o_almost_full", k >= 3, o_almost_full);
      if (o_full !== (k == 7)) report_mismatch("o_full", k == 7, o_full);
    end
    repeat (3) step_cycle();   // hold checked in step_cycle
    if (o_replay_valid !== 1'b1) report_mismatch("o_replay_valid", 1, o_replay_valid);
    drain_queue(20);
  endtask

  task automatic flush_test();
    i_replay_ready = 1'b0;
    for (int k = 0; k < `RQ_DEPTH; k++) begin
      push_one((k < 4) ? HAZ_L1D_CONFLICT : HAZ_STQ_WAIT, 8'hff);
    end
    if (o_full !== 1'b1) report_mismatch("o_full", 1, o_full);
    if (o_replay_valid !== 1'b1) report_mismatch("o_replay_valid", 1, o_replay_valid);
    chk_occ = 1'b0;   // dead slots still occupy the queue
    i_flush = 1'b1;
    step_cycle();
    i_flush = 1'b0;
    if (o_replay_valid !== 1'b0) report_mismatch("o_replay_valid", 0, o_replay_valid);
    i_replay_ready = 1'b1;
    step_cycle();   // first dead entry leaves
    if (o_full !== 1'b0) report_mismatch("o_full", 0, o_full);
    repeat (3) step_cycle();
    if (o_almost_full !== 1'b1) report_mismatch("o_almost_full", 1, o_almost_full);
    repeat (4) step_cycle();   // dead entries leave one per cycle
    if (o_almost_full !== 1'b0) report_mismatch("o_almost_full", 0, o_almost_full);
    chk_occ = 1'b1;
    for (int k = 0; k < `RQ_DEPTH; k++) begin
      push_one(HAZ_L1D_CONFLICT, 8'h00);
    end
    drain_queue(20);
  endtask

  task automatic random_mix_test();
    logic [31:0] r;
    haz_type_t   ty;
    for (int c = 0; c < 300; c++) begin
      r  = next_rand();
      ty = haz_type_t'(r[25:24]);
      i_push_valid = 1'b0;
      if (!o_full && r[0] && c < 260) begin
        // missu masks only use the low bits
        start_push(ty, (ty == HAZ_MISSU_WAIT) ? haz_mask_t'(r[11:8]) : r[15:8]);
      end
      i_stq_resolve_valid   = r[1];
      i_stq_resolve_oh      = r[23:16];
      i_missu_full          = r[2] | r[3];   // mostly full
      i_missu_resolve_valid = r[4];
      i_missu_resolve_oh    = r[30:27];
      i_replay_ready        = r[5] | r[6];
      step_cycle();
    end
    idle_inputs();
    drain_queue(200);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    idle_inputs();
    i_reset_n       = 1'b0;
    i_replay_ready  = 1'b0;
    i_push_tag      = '0;
    i_push_haz_type = HAZ_L1D_CONFLICT;
    i_push_haz_mask = '0;
    i_push_paddr    = '0;
    i_push_size     = '0;
    for (int k = 0; k < N_TAGS; k++) begin
      sb_pend[k] = 1'b0;
    end
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    if (o_replay_valid !== 1'b0) report_mismatch("o_replay_valid", 0, o_replay_valid);

    l1d_conflict_test();
    stq_wait_test();
    missu_test();
    backpressure_test();
    flush_test();
    random_mix_test();

    $display("summary: %0d value errors, %0d other errors after %0d cycles",
             err_val, err_other, cycle_cnt);
    if (err_val + err_other == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== source/lsu_replay_top.sv ====
`include "lsu_replay_config.svh"

module lsu_replay_top
  import lsu_replay_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // hazard push from lsu pipe
  input  logic                    i_push_valid,
  input  rob_tag_t                i_push_tag,
  input  haz_type_t               i_push_haz_type,
  input  haz_mask_t               i_push_haz_mask,
  input  paddr_t                  i_push_paddr,
  input  access_size_t            i_push_size,

  // resolve events and flush
  input  logic                    i_stq_resolve_valid,
  input  logic [`STQ_DEPTH-1:0]   i_stq_resolve_oh,
  input  logic                    i_missu_full,
  input  logic                    i_missu_resolve_valid,
  input  logic [`MISSU_DEPTH-1:0] i_missu_resolve_oh,
  input  logic                    i_flush,

  // re-issue
  output logic                    o_replay_valid,
  input  logic                    i_replay_ready,
  output rob_tag_t                o_replay_tag,
  output haz_type_t               o_replay_haz_type,
  output paddr_t                  o_replay_paddr,
  output access_size_t            o_replay_size,

  output logic                    o_full,
  output logic                    o_almost_full
);

  replay_push_if  u_push_if  ();
  replay_issue_if u_issue_if ();

  // ------------------------------------------------------------
  // ports to interfaces
  // ------------------------------------------------------------
  assign u_push_if.valid    = i_push_valid;
  assign u_push_if.tag      = i_push_tag;
  assign u_push_if.haz_type = i_push_haz_type;
  assign u_push_if.haz_mask = i_push_haz_mask;
  assign u_push_if.paddr    = i_push_paddr;
  assign u_push_if.size     = i_push_size;

  assign u_issue_if.ready   = i_replay_ready;
  assign o_replay_valid     = u_issue_if.valid;
  assign o_replay_tag       = u_issue_if.tag;
  assign o_replay_haz_type  = u_issue_if.haz_type;
  assign o_replay_paddr     = u_issue_if.paddr;
  assign o_replay_size      = u_issue_if.size;

  replay_queue u_replay_queue (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .push                  (u_push_if.dst),
    .issue                 (u_issue_if.src),
    .i_stq_resolve_valid   (i_stq_resolve_valid),
    .i_stq_resolve_oh      (i_stq_resolve_oh),
    .i_missu_full          (i_missu_full),
    .i_missu_resolve_valid (i_missu_resolve_valid),
    .i_missu_resolve_oh    (i_missu_resolve_oh),
    .i_flush               (i_flush),
    .o_full                (o_full),
    .o_almost_full         (o_almost_full)
  );

endmodule

// ==== replay_queue/replay_queue.sv ====
`include "lsu_replay_config.svh"

module replay_queue
  import lsu_replay_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  replay_push_if.dst              push,
  replay_issue_if.src             issue,

  input  logic                    i_stq_resolve_valid,
  input  logic [`STQ_DEPTH-1:0]   i_stq_resolve_oh,
  input  logic                    i_missu_full,
  input  logic                    i_missu_resolve_valid,
  input  logic [`MISSU_DEPTH-1:0] i_missu_resolve_oh,
  input  logic                    i_flush,

  output logic                    o_full,
  output logic                    o_almost_full
);

  localparam int PAYLOAD_W = $bits(paddr_t) + $bits(access_size_t);

  logic [`RQ_DEPTH-1:0] r_valid;
  logic [`RQ_DEPTH-1:0] r_dead;
  rob_tag_t             r_tag  [`RQ_DEPTH];
  haz_type_t            r_type [`RQ_DEPTH];
  haz_mask_t            r_mask [`RQ_DEPTH];

  logic                 w_alloc;
  rq_id_t               w_alloc_id;
  logic                 w_free;
  logic                 w_fire;
  logic                 w_any_ready;
  logic                 w_pick_dead;
  logic [`RQ_DEPTH-1:0] w_ready_list;
  logic [`RQ_DEPTH-1:0] w_grant_oh;
  rq_id_t               w_grant_idx;
  rq_id_t               r_sel_ptr;
  haz_mask_t            w_stq_clr;
  haz_mask_t            w_missu_clr;
  logic [PAYLOAD_W-1:0] w_wr_data;
  logic [PAYLOAD_W-1:0] w_rd_data;
  logic [`RQ_ID_W:0]    r_count;    // 0 .. depth

  assign w_alloc     = push.valid;
  assign w_any_ready = |w_ready_list;
  assign w_pick_dead = w_any_ready & r_dead[w_grant_idx];
  assign w_fire      = issue.valid & issue.ready;
  assign w_free      = w_fire | w_pick_dead;   // dead picks leave without issuing

  assign w_stq_clr   = i_stq_resolve_valid   ? haz_mask_t'(i_stq_resolve_oh)   : '0;
  assign w_missu_clr = i_missu_resolve_valid ? haz_mask_t'(i_missu_resolve_oh) : '0;

  free_list u_free_list (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_push    (w_free),
    .i_push_id (w_grant_idx),
    .i_pop     (w_alloc),
    .o_pop_id  (w_alloc_id)
  );

  // ------------------------------------------------------------
  // entry state
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_dead  <= '0;
    end else begin
      for (int q = 0; q < `RQ_DEPTH; q++) begin
        if (w_alloc && (w_alloc_id == rq_id_t'(q))) begin
          r_valid[q] <= 1'b1;
          r_dead[q]  <= 1'b0;
        end else if (w_free && w_grant_oh[q]) begin
          r_valid[q] <= 1'b0;
          r_dead[q]  <= 1'b0;
        end else if (i_flush && r_valid[q]) begin
          r_dead[q]  <= 1'b1;   // drained later, never issued
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int q = 0; q < `RQ_DEPTH; q++) begin
      if (w_alloc && (w_alloc_id == rq_id_t'(q))) begin
        r_tag[q]  <= push.tag;
        r_type[q] <= push.haz_type;
        // l1d conflict sits one cycle so the bank can free up
        r_mask[q] <= (push.haz_type == HAZ_L1D_CONFLICT) ? haz_mask_t'(1) : push.haz_mask;
      end else begin
        case (r_type[q])
          HAZ_L1D_CONFLICT : r_mask[q] <= '0;
          HAZ_STQ_WAIT     : r_mask[q] <= r_mask[q] & ~w_stq_clr;
          HAZ_MISSU_FULL   : r_mask[q] <= i_missu_full ? r_mask[q] : '0;
          HAZ_MISSU_WAIT   : r_mask[q] <= r_mask[q] & ~w_missu_clr;
        endcase
      end
    end
  end

  always_comb begin
    for (int q = 0; q < `RQ_DEPTH; q++) begin
      w_ready_list[q] = r_valid[q] & ((r_mask[q] == '0) | r_dead[q]);
    end
  end

  // ------------------------------------------------------------
  // pick and issue
  // ------------------------------------------------------------
  replay_select #(.WIDTH(`RQ_DEPTH)) u_select (
    .i_req       (w_ready_list),
    .i_ptr       (r_sel_ptr),
    .o_grant_oh  (w_grant_oh),
    .o_grant_idx (w_grant_idx)
  );

  // pointer parks on a stalled pick so valid and payload hold
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_sel_ptr <= '0;
    end else if (w_free) begin
      r_sel_ptr <= (w_grant_idx == rq_id_t'(`RQ_DEPTH - 1)) ? '0 : w_grant_idx + 1'b1;
    end else if (w_any_ready) begin
      r_sel_ptr <= w_grant_idx;
    end
  end

  assign w_wr_data = {push.paddr, push.size};

  payload_ram #(.WIDTH(PAYLOAD_W), .WORDS(`RQ_DEPTH)) u_payload_ram (
    .i_clk     (i_clk),
    .i_wr      (w_alloc),
    .i_wr_addr (w_alloc_id),
    .i_wr_data (w_wr_data),
    .i_rd_addr (w_grant_idx),
    .o_rd_data (w_rd_data)
  );

  assign issue.valid             = w_any_ready & ~r_dead[w_grant_idx];
  assign issue.tag               = r_tag[w_grant_idx];
  assign issue.haz_type          = r_type[w_grant_idx];
  assign {issue.paddr, issue.size} = w_rd_data;

  // ------------------------------------------------------------
  // occupancy
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= '0;
    end else begin
      case ({w_free, w_alloc})
        2'b01   : r_count <= r_count + 1'b1;
        2'b10   : r_count <= r_count - 1'b1;
        default : r_count <= r_count;   // push and free cancel
      endcase
    end
  end

  assign o_full        = (r_count == (`RQ_ID_W+1)'(`RQ_DEPTH));
  assign o_almost_full = (r_count >= (`RQ_ID_W+1)'(`RQ_DEPTH - `RQ_ALMOST_MARGIN));

endmodule

// ==== replay_queue/replay_select.sv ====
module replay_select
  import lsu_replay_pkg::*;
#(
  parameter int WIDTH = 8
)
(
  input  logic [WIDTH-1:0] i_req,
  input  rq_id_t           i_ptr,
  output logic [WIDTH-1:0] o_grant_oh,
  output rq_id_t           o_grant_idx
);

  logic [WIDTH-1:0] w_ptr_mask;   // bits at or above the pointer
  logic [WIDTH-1:0] w_upper_req;
  logic [WIDTH-1:0] w_pick_src;

  assign w_ptr_mask  = ~((WIDTH'(1) << i_ptr) - WIDTH'(1));
  assign w_upper_req = i_req & w_ptr_mask;

  // nothing above the pointer, wrap to the bottom
  assign w_pick_src  = (|w_upper_req) ? w_upper_req : i_req;

  // isolate lowest set bit
  assign o_grant_oh  = w_pick_src & (~w_pick_src + WIDTH'(1));

  // ------------------------------------------------------------
  // one-hot to binary
  // ------------------------------------------------------------
  always_comb begin
    o_grant_idx = '0;
    for (int i = 0; i < WIDTH; i++) begin
      if (o_grant_oh[i]) begin
        o_grant_idx = rq_id_t'(i);
      end
    end
  end

endmodule

// ==== replay_queue/payload_ram.sv ====
module payload_ram
  import lsu_replay_pkg::*;
#(
  parameter int WIDTH = 34,
  parameter int WORDS = 8
)
(
  input  logic             i_clk,

  input  logic             i_wr,
  input  rq_id_t           i_wr_addr,
  input  logic [WIDTH-1:0] i_wr_data,

  input  rq_id_t           i_rd_addr,
  output logic [WIDTH-1:0] o_rd_data
);

  logic [WIDTH-1:0] r_mem [WORDS];

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_mem[i_wr_addr] <= i_wr_data;
    end
  end

  // lutram style read, same cycle as the pick
  assign o_rd_data = r_mem[i_rd_addr];

endmodule

// ==== replay_queue/free_list.sv ====
`include "lsu_replay_config.svh"

module free_list
  import lsu_replay_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_reset_n,

  input  logic   i_push,     // slot released
  input  rq_id_t i_push_id,

  input  logic   i_pop,      // slot allocated
  output rq_id_t o_pop_id
);

  rq_id_t r_ring [`RQ_DEPTH];
  rq_id_t r_head;
  rq_id_t r_tail;

  function automatic rq_id_t next_ptr(input rq_id_t ptr);
    if (ptr == rq_id_t'(`RQ_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ------------------------------------------------------------
  // ring of free ids, full at reset
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_tail <= '0;
      for (int i = 0; i < `RQ_DEPTH; i++) begin
        r_ring[i] <= rq_id_t'(i);
      end
    end else begin
      if (i_pop) begin
        r_head <= next_ptr(r_head);
      end
      if (i_push) begin
        r_ring[r_tail] <= i_push_id;
        r_tail         <= next_ptr(r_tail);
      end
    end
  end

  // occupancy lives in the queue, head is always a free id when popped
  assign o_pop_id = r_ring[r_head];

endmodule

// ==== common/lsu_replay_if.sv ====
// hazard push from lsu pipe into the replay queue
// no ready, source checks o_full before pushing
interface replay_push_if
  import lsu_replay_pkg::*;
();

  logic         valid;
  rob_tag_t     tag;
  haz_type_t    haz_type;
  haz_mask_t    haz_mask;
  paddr_t       paddr;
  access_size_t size;

  modport src (output valid, tag, haz_type, haz_mask, paddr, size);
  modport dst (input  valid, tag, haz_type, haz_mask, paddr, size);

endinterface

// re-issue toward the lsu pipe, valid/ready handshake
interface replay_issue_if
  import lsu_replay_pkg::*;
();

  logic         valid;
  logic         ready;
  rob_tag_t     tag;
  haz_type_t    haz_type;
  paddr_t       paddr;
  access_size_t size;

  modport src (output valid, tag, haz_type, paddr, size,
               input  ready);
  modport dst (input  valid, tag, haz_type, paddr, size,
               output ready);

endinterface

// ==== common/lsu_replay_pkg.sv ====
`include "lsu_replay_config.svh"

package lsu_replay_pkg;

  // ------------------------------------------------------------
  // plain vector types
  // ------------------------------------------------------------
  typedef logic [`RQ_ID_W-1:0]   rq_id_t;     // replay slot number
  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
  typedef logic [`PADDR_W-1:0]   paddr_t;

  // 0 byte, 1 half, 2 word, 3 double
  typedef logic [1:0]            access_size_t;

  // one bit per stq or missu entry the access waits on
  typedef logic [`HAZ_IDX_W-1:0] haz_mask_t;

  // ------------------------------------------------------------
  // hazard reported by the lsu pipeline
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    HAZ_L1D_CONFLICT = 2'd0,  // bank conflict, retry next cycle
    HAZ_STQ_WAIT     = 2'd1,  // older stores not yet resolved
    HAZ_MISSU_FULL   = 2'd2,  // no free miss unit entry
    HAZ_MISSU_WAIT   = 2'd3   // line being refilled by missu
  } haz_type_t;

endpackage

// ==== common/lsu_replay_config.svh ====
`ifndef LSU_REPLAY_CONFIG_SVH
`define LSU_REPLAY_CONFIG_SVH

// ------------------------------------------------------------
// replay queue sizing
// ------------------------------------------------------------
`define RQ_DEPTH          8
`define RQ_ID_W           3
`define RQ_ALMOST_MARGIN  4   // one slot per lsu stage in flight

// ------------------------------------------------------------
// core widths seen by the queue
// ------------------------------------------------------------
`define ROB_TAG_W         6
`define PADDR_W           32
`define STQ_DEPTH         8
`define MISSU_DEPTH       4
`define HAZ_IDX_W         8   // max of stq and missu depth

`endif
